// File: files.f
+incdir+hw
+incdir+tb
hw/cpuPkg.sv
hw/regFile.sv
hw/alu.sv
hw/pcUnit.sv
hw/controlUnit.sv
hw/cpuCore.sv
tb/tbCpu.sv

// File: hw/alu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu (
    input  logic [`CPU_WORD-1:0] a,
    input  logic [`CPU_WORD-1:0] b,
    input  cpuPkg::aluOpT        aluOp,
    output logic [`CPU_WORD-1:0] result,
    output logic                 takeBranch
);
    logic aIsZero;
    logic aIsNeg;

    assign aIsZero = (a == '0);
    assign aIsNeg  = a[`CPU_WORD-1];

    always_comb begin
        result = a - b; // also the compare value for branches
        case (aluOp)
            cpuPkg::ALU_ADD: result = a + b;
            cpuPkg::ALU_SUB: result = a - b;
            cpuPkg::ALU_AND: result = a & b;
            cpuPkg::ALU_OR:  result = a | b;
            cpuPkg::ALU_NOT: result = ~a;
            cpuPkg::ALU_TCP: result = ~a + 1'b1;
            cpuPkg::ALU_SHL: result = {a[`CPU_WORD-2:0], 1'b0};
            cpuPkg::ALU_SHR: result = {a[`CPU_WORD-1], a[`CPU_WORD-1:1]}; // arithmetic
            cpuPkg::ALU_LHI: result = {b[7:0], 8'h00};
            default: ;
        endcase
    end

    always_comb begin
        case (aluOp)
            cpuPkg::ALU_BNE: takeBranch = (a != b);
            cpuPkg::ALU_BEQ: takeBranch = (a == b);
            cpuPkg::ALU_BGZ: takeBranch = !aIsNeg && !aIsZero;
            cpuPkg::ALU_BLZ: takeBranch = aIsNeg;
            default:         takeBranch = 1'b0;
        endcase
    end

endmodule

// File: hw/controlUnit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module controlUnit (
    input  logic                 clk,
    input  logic                 rst,
    input  cpuPkg::instrT        instr,
    input  logic [`CPU_WORD-1:0] rsData,
    input  logic                 takeBranch,
    output logic                 regWrite,
    output cpuPkg::wbSelT        writeSel,
    output logic [1:0]           destReg,
    output cpuPkg::aluOpT        aluOp,
    output logic                 aluSrcImm,
    output logic                 immSigned,
    output cpuPkg::pcSelT        pcSel,
    output logic                 pcHold,
    output logic                 memRead,
    output logic                 memWrite,
    output logic [`CPU_WORD-1:0] outputPort,
    output logic [`CPU_WORD-1:0] numInst,
    output logic                 halted
);
    logic wantWrite; // decoded register write, before the halt gate
    logic wantStore;
    logic isWwd;
    logic isHlt;

    always_comb begin
        wantWrite = 1'b0;
        wantStore = 1'b0;
        writeSel  = cpuPkg::WB_ALU;
        destReg   = instr.iForm.rt; // I-type default
        aluOp     = cpuPkg::ALU_ADD;
        aluSrcImm = 1'b1;
        immSigned = 1'b1;
        pcSel     = cpuPkg::PC_SEQ;
        memRead   = 1'b0;
        isWwd     = 1'b0;
        isHlt     = 1'b0;
        case (instr.rForm.opcode)
            cpuPkg::OP_ADI: wantWrite = 1'b1;
            cpuPkg::OP_ORI: begin
                wantWrite = 1'b1;
                aluOp     = cpuPkg::ALU_OR;
                immSigned = 1'b0; // zero extended
            end
            cpuPkg::OP_LHI: begin
                wantWrite = 1'b1;
                aluOp     = cpuPkg::ALU_LHI;
            end
            cpuPkg::OP_LWD: begin
                wantWrite = 1'b1;
                writeSel  = cpuPkg::WB_MEM;
                memRead   = 1'b1;
            end
            cpuPkg::OP_SWD: wantStore = 1'b1; // address is rs + imm
            cpuPkg::OP_BNE, cpuPkg::OP_BEQ, cpuPkg::OP_BGZ, cpuPkg::OP_BLZ: begin
                aluSrcImm = 1'b0;
                pcSel     = takeBranch ? cpuPkg::PC_BRANCH : cpuPkg::PC_SEQ;
                case (instr.rForm.opcode)
                    cpuPkg::OP_BNE: aluOp = cpuPkg::ALU_BNE;
                    cpuPkg::OP_BEQ: aluOp = cpuPkg::ALU_BEQ;
                    cpuPkg::OP_BGZ: aluOp = cpuPkg::ALU_BGZ;
                    default:        aluOp = cpuPkg::ALU_BLZ;
                endcase
            end
            cpuPkg::OP_JMP: pcSel = cpuPkg::PC_JUMP;
            cpuPkg::OP_JAL: begin
                pcSel     = cpuPkg::PC_JUMP;
                wantWrite = 1'b1;
                writeSel  = cpuPkg::WB_PC1;
                destReg   = 2'd2; // link register
            end
            cpuPkg::OP_RTYPE: begin
                destReg   = instr.rForm.rd;
                aluSrcImm = 1'b0;
                case (instr.rForm.func)
                    cpuPkg::FN_ADD: begin wantWrite = 1'b1; aluOp = cpuPkg::ALU_ADD; end
                    cpuPkg::FN_SUB: begin wantWrite = 1'b1; aluOp = cpuPkg::ALU_SUB; end
                    cpuPkg::FN_AND: begin wantWrite = 1'b1; aluOp = cpuPkg::ALU_AND; end
                    cpuPkg::FN_ORR: begin wantWrite = 1'b1; aluOp = cpuPkg::ALU_OR; end
                    cpuPkg::FN_NOT: begin wantWrite = 1'b1; aluOp = cpuPkg::ALU_NOT; end
                    cpuPkg::FN_TCP: begin wantWrite = 1'b1; aluOp = cpuPkg::ALU_TCP; end
                    cpuPkg::FN_SHL: begin wantWrite = 1'b1; aluOp = cpuPkg::ALU_SHL; end
                    cpuPkg::FN_SHR: begin wantWrite = 1'b1; aluOp = cpuPkg::ALU_SHR; end
                    cpuPkg::FN_JPR: pcSel = cpuPkg::PC_REG;
                    cpuPkg::FN_WWD: isWwd = 1'b1;
                    cpuPkg::FN_HLT: isHlt = 1'b1;
                    default: ; // unknown function retires as a no-op
                endcase
            end
            default: ; // unused opcodes
        endcase
    end

    assign regWrite = wantWrite && !halted;
    assign memWrite = wantStore && !halted;
    assign pcHold   = halted;

    always_ff @(posedge clk) begin
        if (rst) begin
            halted     <= 1'b0;
            numInst    <= '0;
            outputPort <= '0;
        end else if (!halted) begin
            numInst <= numInst + 1'b1; // HLT itself is counted
            if (isWwd)
                outputPort <= rsData;
            if (isHlt)
                halted <= 1'b1;
        end
    end

endmodule

// File: hw/cpuCore.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpuCore (
    input  logic                 clk,
    input  logic                 rst,
    output logic [`CPU_WORD-1:0] instrAddr,
    input  logic [`CPU_WORD-1:0] instr,
    output logic [`CPU_WORD-1:0] dataAddr,
    output logic [`CPU_WORD-1:0] writeData,
    input  logic [`CPU_WORD-1:0] readData,
    output logic                 memRead,
    output logic                 memWrite,
    output logic [`CPU_WORD-1:0] outputPort,
    output logic [`CPU_WORD-1:0] numInst,
    output logic                 halted
);
    cpuPkg::instrT        instrWord;
    cpuPkg::wbSelT        writeSel;
    cpuPkg::aluOpT        aluOp;
    cpuPkg::pcSelT        pcSel;
    logic                 regWrite;
    logic [1:0]           destReg;
    logic                 aluSrcImm;
    logic                 immSigned;
    logic                 pcHold;
    logic                 takeBranch;
    logic [`CPU_WORD-1:0] pc;
    logic [`CPU_WORD-1:0] pcPlusOne;
    logic [`CPU_WORD-1:0] imm;
    logic [`CPU_WORD-1:0] rsData;
    logic [`CPU_WORD-1:0] rtData;
    logic [`CPU_WORD-1:0] aluB;
    logic [`CPU_WORD-1:0] aluResult;
    logic [`CPU_WORD-1:0] writeValue;

    assign instrWord = instr;
    assign instrAddr = pc;
    assign dataAddr  = aluResult; // rs + imm for LWD and SWD
    assign writeData = rtData;
    assign aluB      = aluSrcImm ? imm : rtData;

    assign writeValue = (writeSel == cpuPkg::WB_MEM) ? readData :
                        (writeSel == cpuPkg::WB_PC1) ? pcPlusOne : aluResult;

    controlUnit i_controlUnit (
        .clk(clk), .rst(rst), .instr(instrWord), .rsData(rsData), .takeBranch(takeBranch),
        .regWrite(regWrite), .writeSel(writeSel), .destReg(destReg), .aluOp(aluOp),
        .aluSrcImm(aluSrcImm), .immSigned(immSigned), .pcSel(pcSel), .pcHold(pcHold),
        .memRead(memRead), .memWrite(memWrite), .outputPort(outputPort),
        .numInst(numInst), .halted(halted)
    );

    pcUnit i_pcUnit (
        .clk(clk), .rst(rst), .instr(instrWord), .immSigned(immSigned), .pcSel(pcSel),
        .pcHold(pcHold), .takeBranch(takeBranch), .rsData(rsData), .pc(pc),
        .pcPlusOne(pcPlusOne), .imm(imm)
    );

    regFile i_regFile (
        .clk(clk), .rst(rst), .rs(instrWord.rForm.rs), .rt(instrWord.rForm.rt),
        .destReg(destReg), .writeEn(regWrite), .writeValue(writeValue),
        .rsData(rsData), .rtData(rtData)
    );

    alu i_alu (
        .a(rsData), .b(aluB), .aluOp(aluOp), .result(aluResult), .takeBranch(takeBranch)
    );

endmodule

// File: hw/cpuPkg.sv
package cpuPkg;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_BGZ   = 4'd2,
        OP_BLZ   = 4'd3,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_JAL   = 4'd10,
        OP_RTYPE = 4'd15
    } opcodeT;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_JPR = 6'd25,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funcT;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR,
        ALU_LHI, // immediate moved to the upper byte
        ALU_BNE, ALU_BEQ, ALU_BGZ, ALU_BLZ
    } aluOpT;

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pcSelT;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC1} wbSelT;

    typedef struct packed {
        opcodeT     opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        funcT       func;
    } rFormT;

    typedef struct packed {
        opcodeT     opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm8; // {rs, rt, imm8} doubles as the jump target
    } iFormT;

    typedef union packed {
        rFormT rForm;
        iFormT iForm;
    } instrT;

endpackage

// File: hw/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data, address and instruction width
`define CPU_WORD 16

`define CPU_NREGS 4

// first instruction fetched after reset
`define CPU_RESET_PC 0

`endif

// File: hw/pcUnit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module pcUnit (
    input  logic                 clk,
    input  logic                 rst,
    input  cpuPkg::instrT        instr,
    input  logic                 immSigned,
    input  cpuPkg::pcSelT        pcSel,
    input  logic                 pcHold,
    input  logic                 takeBranch,
    input  logic [`CPU_WORD-1:0] rsData,
    output logic [`CPU_WORD-1:0] pc,
    output logic [`CPU_WORD-1:0] pcPlusOne,
    output logic [`CPU_WORD-1:0] imm
);
    logic [`CPU_WORD-1:0] branchTarget;
    logic [`CPU_WORD-1:0] jumpTarget;
    logic [`CPU_WORD-1:0] nextPc;

    assign imm = immSigned ? {{(`CPU_WORD-8){instr.iForm.imm8[7]}}, instr.iForm.imm8}
                           : {{(`CPU_WORD-8){1'b0}}, instr.iForm.imm8};

    assign pcPlusOne    = pc + 1'b1;
    assign branchTarget = pcPlusOne + imm; // branches decode with immSigned set
    // upper bits of pc+1 followed by the 12-bit target field
    assign jumpTarget   = {pcPlusOne[`CPU_WORD-1:12], instr.iForm.rs, instr.iForm.rt,
                           instr.iForm.imm8};

    always_comb begin
        case (pcSel)
            cpuPkg::PC_BRANCH: nextPc = takeBranch ? branchTarget : pcPlusOne;
            cpuPkg::PC_JUMP:   nextPc = jumpTarget;
            cpuPkg::PC_REG:    nextPc = rsData; // JPR
            default:           nextPc = pcPlusOne;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `CPU_WORD'(`CPU_RESET_PC);
        end else if (!pcHold) begin
            pc <= nextPc;
        end
    end

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module regFile (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [$clog2(`CPU_NREGS)-1:0] rs,
    input  logic [$clog2(`CPU_NREGS)-1:0] rt,
    input  logic [$clog2(`CPU_NREGS)-1:0] destReg,
    input  logic                         writeEn,
    input  logic [`CPU_WORD-1:0]         writeValue,
    output logic [`CPU_WORD-1:0]         rsData,
    output logic [`CPU_WORD-1:0]         rtData
);
    logic [`CPU_WORD-1:0] regs [`CPU_NREGS];

    // reads see the value before this cycle's write
    assign rsData = regs[rs];
    assign rtData = regs[rt];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[destReg] <= writeValue;
        end
    end

endmodule

// File: tb/tbTasks.svh
logic [15:0] mRegs [4];
logic [15:0] mMem [256];
logic [15:0] mOut [$];
int progPos;

function automatic logic [15:0] rIns(input logic [5:0] fn, input logic [1:0] rs, rt, rd);
    return {4'hf, rs, rt, rd, fn};
endfunction

function automatic logic [15:0] iIns(input logic [3:0] op, input logic [1:0] rs, rt,
                                     input logic [7:0] imm);
    return {op, rs, rt, imm};
endfunction

task automatic emit(input logic [15:0] word);
    imem[progPos] = word;
    progPos++;
endtask

task automatic clearProgram();
    progPos = 0;
    for (int i = 0; i < 256; i++)
        imem[i] = 16'hf01d; // HLT everywhere
endtask

// instruction-set model, run from the program and the initial data array
task automatic modelRun(output int count);
    logic [15:0] pc, w, se, nextPc, addr;
    logic [1:0] rs, rt, rd;
    bit done;
    pc = `CPU_RESET_PC;
    count = 0;
    done = 0;
    mOut.delete();
    foreach (mRegs[i])
        mRegs[i] = '0;
    foreach (mMem[i])
        mMem[i] = dmem[i];
    while (!done && count < 2000) begin
        w = imem[pc[7:0]];
        rs = w[11:10];
        rt = w[9:8];
        rd = w[7:6];
        se = {{8{w[7]}}, w[7:0]};
        addr = mRegs[rs] + se;
        nextPc = pc + 16'd1;
        count++;
        case (w[15:12])
            4'd0: if (mRegs[rs] != mRegs[rt]) nextPc = pc + 16'd1 + se;
            4'd1: if (mRegs[rs] == mRegs[rt]) nextPc = pc + 16'd1 + se;
            4'd2: if ($signed(mRegs[rs]) > 0) nextPc = pc + 16'd1 + se;
            4'd3: if (mRegs[rs][15]) nextPc = pc + 16'd1 + se;
            4'd4: mRegs[rt] = addr;
            4'd5: mRegs[rt] = mRegs[rs] | {8'h00, w[7:0]};
            4'd6: mRegs[rt] = {w[7:0], 8'h00};
            4'd7: mRegs[rt] = mMem[addr[7:0]];
            4'd8: mMem[addr[7:0]] = mRegs[rt];
            4'd9: nextPc = {nextPc[15:12], w[11:0]};
            4'd10: begin
                mRegs[2] = nextPc; // link
                nextPc = {nextPc[15:12], w[11:0]};
            end
            4'd15: case (w[5:0])
                6'd0: mRegs[rd] = mRegs[rs] + mRegs[rt];
                6'd1: mRegs[rd] = mRegs[rs] - mRegs[rt];
                6'd2: mRegs[rd] = mRegs[rs] & mRegs[rt];
                6'd3: mRegs[rd] = mRegs[rs] | mRegs[rt];
                6'd4: mRegs[rd] = ~mRegs[rs];
                6'd5: mRegs[rd] = -mRegs[rs];
                6'd6: mRegs[rd] = mRegs[rs] << 1;
                6'd7: mRegs[rd] = $signed(mRegs[rs]) >>> 1;
                6'd25: nextPc = mRegs[rs];
                6'd28: mOut.push_back(mRegs[rs]);
                6'd29: done = 1;
                default: ;
            endcase
            default: ;
        endcase
        pc = nextPc;
    end
endtask

task automatic testRType();
    logic [31:0] a, b;
    clearProgram();
    a = lcgNext();
    b = lcgNext();
    emit(iIns(4'd6, 2'd0, 2'd0, a[31:24]));
    emit(iIns(4'd5, 2'd0, 2'd0, a[23:16]));
    emit(iIns(4'd6, 2'd0, 2'd1, b[31:24]));
    emit(iIns(4'd5, 2'd1, 2'd1, b[23:16]));
    for (int fn = 0; fn < 8; fn++) begin
        emit(rIns(fn[5:0], 2'd0, 2'd1, 2'd3));
        emit(rIns(6'd28, 2'd3, 2'd0, 2'd0));
    end
    runProgram(0);
    checkEq(seenOut.size(), 8, "R-type WWD count");
endtask

task automatic testImmediate();
    logic [31:0] v;
    clearProgram();
    v = lcgNext();
    emit(iIns(4'd6, 2'd0, 2'd1, v[31:24]));
    emit(iIns(4'd4, 2'd1, 2'd2, {1'b1, v[22:16]})); // negative immediate
    emit(rIns(6'd28, 2'd2, 2'd0, 2'd0));
    emit(iIns(4'd5, 2'd1, 2'd3, {1'b1, v[14:8]})); // zero extended
    emit(rIns(6'd28, 2'd3, 2'd0, 2'd0));
    emit(iIns(4'd6, 2'd0, 2'd0, v[7:0]));
    emit(rIns(6'd28, 2'd0, 2'd0, 2'd0));
    runProgram(0);
    checkEq(seenOut.size(), 3, "immediate WWD count");
endtask

task automatic testLoadStore();
    logic [31:0] v;
    logic [15:0] vals [4];
    logic [7:0] off;
    clearProgram();
    emit(iIns(4'd4, 2'd0, 2'd0, 8'h40)); // base address
    for (int k = 0; k < 4; k++) begin
        v = lcgNext();
        vals[k] = v[31:16];
        off = 8'(k * 5 - 8);
        emit(iIns(4'd6, 2'd0, 2'd1, v[31:24]));
        emit(iIns(4'd5, 2'd1, 2'd1, v[23:16]));
        emit(iIns(4'd8, 2'd0, 2'd1, off));
    end
    for (int k = 0; k < 4; k++) begin
        emit(iIns(4'd7, 2'd0, 2'd2, 8'(k * 5 - 8)));
        emit(rIns(6'd28, 2'd2, 2'd0, 2'd0));
    end
    runProgram(0);
    for (int k = 0; k < 4; k++) begin
        off = 8'(k * 5 - 8);
        checkEq(dmem[8'(8'h40 + off)], vals[k], "stored word");
        checkEq(seenOut[k], vals[k], "loaded word");
    end
endtask

task automatic testBranches();
    logic [15:0] wrong;
    wrong = iIns(4'd8, 2'd1, 2'd3, 8'h60); // writes the marker 16'hfffd
    clearProgram();
    emit(iIns(4'd4, 2'd0, 2'd0, 8'd5));
    emit(iIns(4'd4, 2'd1, 2'd1, 8'd5));
    emit(iIns(4'd4, 2'd3, 2'd3, 8'hfd));
    emit(iIns(4'd0, 2'd0, 2'd1, 8'd1)); // BNE not taken
    emit(iIns(4'd1, 2'd0, 2'd1, 8'd1)); // BEQ taken
    emit(wrong);
    emit(iIns(4'd2, 2'd0, 2'd0, 8'd1));
    emit(wrong);
    emit(iIns(4'd3, 2'd3, 2'd0, 8'd1));
    emit(wrong);
    emit(iIns(4'd3, 2'd0, 2'd0, 8'd1)); // BLZ not taken
    emit(iIns(4'd2, 2'd3, 2'd0, 8'd1)); // BGZ not taken
    emit(iIns(4'd0, 2'd0, 2'd3, 8'd1));
    emit(wrong);
    emit({4'd10, 12'd17}); // JAL, link is 15
    emit(rIns(6'd28, 2'd2, 2'd0, 2'd0));
    emit({4'd9, 12'd20});
    emit(rIns(6'd28, 2'd2, 2'd0, 2'd0));
    emit(rIns(6'd25, 2'd2, 2'd0, 2'd0)); // JPR back to 15
    emit(wrong);
    emit(16'hf01d);
    runProgram(0);
    checkEq(seenOut.size(), 2, "branch WWD count");
    checkEq(seenOut[0], 15, "JAL link value");
    for (int i = 0; i < 256; i++)
        checkEq(dmem[i] == 16'hfffd, 0, $sformatf("wrong-path store at %0d", i));
endtask

task automatic testHalt();
    clearProgram();
    emit(iIns(4'd4, 2'd0, 2'd0, 8'd7));
    emit(rIns(6'd28, 2'd0, 2'd0, 2'd0));
    emit(16'hf01d);
    emit(iIns(4'd4, 2'd0, 2'd0, 8'd1)); // never retires
    emit(iIns(4'd8, 2'd0, 2'd0, 8'h10));
    emit(rIns(6'd28, 2'd0, 2'd0, 2'd0));
    runProgram(0);
    checkEq(numInst, 3, "count including HLT");
endtask

task automatic testResetRecovery();
    clearProgram();
    emit(iIns(4'd4, 2'd0, 2'd0, 8'd40));
    emit(iIns(4'd4, 2'd1, 2'd1, 8'd3));
    emit(iIns(4'd8, 2'd0, 2'd1, 8'h80));
    emit(iIns(4'd4, 2'd0, 2'd0, 8'hff));
    emit(rIns(6'd28, 2'd0, 2'd0, 2'd0)); // shows the loop counter
    emit(iIns(4'd0, 2'd0, 2'd3, 8'hfb)); // loop back while r0 != 0
    emit(rIns(6'd28, 2'd1, 2'd0, 2'd0));
    emit(16'hf01d);
    runProgram(50);
endtask

// File: tb/tbCpu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module tbCpu;
    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [`CPU_WORD-1:0] instrAddr, instr, dataAddr, writeData, readData;
    logic [`CPU_WORD-1:0] outputPort, numInst;
    logic memRead, memWrite, halted;
    logic [`CPU_WORD-1:0] imem [256];
    logic [`CPU_WORD-1:0] dmem [256];
    logic [`CPU_WORD-1:0] seenOut [$]; // values shown by WWD, in order
    logic wwdPending = 1'b0;
    logic [31:0] seed = 32'hbe22eee0;

    `include "tbTasks.svh"

    always #10 clk = ~clk;

    assign instr    = imem[instrAddr[7:0]];
    assign readData = memRead ? dmem[dataAddr[7:0]] : '0;

    cpuCore i_dut (.*);

    always @(posedge clk) begin
        if (memWrite && !rst)
            dmem[dataAddr[7:0]] <= writeData;
    end

    // outputPort is stable one half cycle after the WWD edge
    always @(negedge clk) begin
        if (rst) begin
            seenOut.delete();
            wwdPending = 1'b0;
        end else begin
            if (wwdPending)
                seenOut.push_back(outputPort);
            wwdPending = !halted && instr[15:12] == 4'hf && instr[5:0] == 6'd28;
        end
    end

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic checkEq(input logic [31:0] actual, expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s, got %h expected %h", $time, what, actual,
                     expected);
            $display("Regression failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic fillData();
        for (int i = 0; i < 256; i++)
            dmem[i] = {i[7:0], ~i[7:0]}; // never equals the wrong-path marker
    endtask

    task automatic compareState(input int count);
        checkEq(numInst, count, "retired instruction count");
        checkEq(seenOut.size(), mOut.size(), "number of WWD values");
        foreach (mOut[i])
            checkEq(seenOut[i], mOut[i], $sformatf("WWD value %0d", i));
        foreach (mMem[i])
            checkEq(dmem[i], mMem[i], $sformatf("data word %0d", i));
    endtask

    task automatic runProgram(input int resetAt);
        int cycles;
        int count;
        @(posedge clk);
        rst <= 1'b1;
        fillData();
        modelRun(count);
        repeat (10) @(posedge clk);
        checkEq(halted, 0, "halted after reset");
        rst <= 1'b0;
        if (resetAt > 0) begin // reset in the middle of the run
            repeat (resetAt) @(posedge clk);
            rst <= 1'b1;
            repeat (10) @(posedge clk);
            @(negedge clk);
            checkEq(numInst, 0, "numInst after reset");
            checkEq(outputPort, 0, "outputPort after reset");
            fillData();
            @(posedge clk);
            rst <= 1'b0;
        end
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: the core did not halt within 2000 cycles");
            $display("Regression failed");
            $fatal(1, "no halt");
        end
        compareState(count);
        repeat (20) @(negedge clk);
        checkEq(halted, 1, "halted stays high");
        compareState(count);
    endtask

    initial begin
        clearProgram();
        testRType();
        testImmediate();
        testLoadStore();
        testBranches();
        testHalt();
        testResetRecovery();
        $display("Regression passed");
        $finish;
    end

endmodule
